//--- design/scsiDmaPkg.sv
// Shared sequencer codes, APB offsets and FIFO word type. Byte 0 of a FIFO word is its MSB
`default_nettype none

package scsiDmaPkg;

    // Sequencer state encoding
    localparam int SM_STATE_W = 5;
    localparam logic [SM_STATE_W-1:0] ST_IDLE         = 5'h00;
    localparam logic [SM_STATE_W-1:0] ST_CPU_STROBE   = 5'h01;
    localparam logic [SM_STATE_W-1:0] ST_CPU_HOLD     = 5'h02;
    localparam logic [SM_STATE_W-1:0] ST_CPU_DONE     = 5'h03;
    localparam logic [SM_STATE_W-1:0] ST_DMA_XFER     = 5'h10;
    localparam logic [SM_STATE_W-1:0] ST_DMA_LATCH    = 5'h11;
    localparam logic [SM_STATE_W-1:0] ST_DMA_RECOVER1 = 5'h12;
    localparam logic [SM_STATE_W-1:0] ST_DMA_RECOVER2 = 5'h13;

    // Product-term vector and the position of each term
    localparam int TERM_W = 24;
    localparam int T_IDLE_HRD     = 0;
    localparam int T_IDLE_HWR     = 1;
    localparam int T_IDLE_DRD     = 2;
    localparam int T_IDLE_DWR     = 3;
    localparam int T_STB_RD       = 4;
    localparam int T_STB_WR       = 5;
    localparam int T_HOLD_RD      = 6;
    localparam int T_HOLD_WR      = 7;
    localparam int T_DONE_REQ_RD  = 8;
    localparam int T_DONE_REQ_WR  = 9;
    localparam int T_DONE_ACK_RD  = 10;
    localparam int T_DONE_ACK_WR  = 11;
    localparam int T_DONE_EXIT_RD = 12;
    localparam int T_DONE_EXIT_WR = 13;
    localparam int T_XFER_RD      = 14;
    localparam int T_XFER_WR      = 15;
    localparam int T_XFER_RD_LAST = 16;
    localparam int T_XFER_WR_LAST = 17;
    localparam int T_LATCH_RD     = 18;
    localparam int T_LATCH_WR     = 19;
    localparam int T_REC1_RD      = 20;
    localparam int T_REC1_WR      = 21;
    localparam int T_REC2_RD      = 22;
    localparam int T_REC2_WR      = 23;

    // APB register map, byte offsets
    localparam int APB_ADDR_W = 8;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_FIFO      = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_SCSI_BASE = 8'h40;

    // One longword, or four bytes with byte 0 first on the SCSI side
    typedef union packed {
        logic [31:0]     word;
        logic [0:3][7:0] bytes;
    } fifoWord_u;

endpackage

`default_nettype wire

//--- design/scsiSmInputs.sv
// Term decoder for the sequencer. Inputs must already be synchronized to BCLK
`timescale 1ns/1ps
`default_nettype none

module scsiSmInputs import scsiDmaPkg::*; (
    input  logic [SM_STATE_W-1:0] state_i,
    input  logic                  cpuReq_i,
    input  logic                  rw_i,
    input  logic                  dmaEn_i,
    input  logic                  dmaDir_i,
    input  logic                  dreqN_i,
    input  logic                  dsack_i,
    input  logic                  fifoFull_i,
    input  logic                  fifoEmpty_i,
    input  logic                  boEq3_i,
    output logic [TERM_W-1:0]     term_o
);

    logic inIdle, inStb, inHold, inDone;
    logic inXfer, inLatch, inRec1, inRec2;
    logic dmaRdGo, dmaWrGo;

    // One-hot view of the state code
    assign inIdle  = state_i == ST_IDLE;
    assign inStb   = state_i == ST_CPU_STROBE;
    assign inHold  = state_i == ST_CPU_HOLD;
    assign inDone  = state_i == ST_CPU_DONE;
    assign inXfer  = state_i == ST_DMA_XFER;
    assign inLatch = state_i == ST_DMA_LATCH;
    assign inRec1  = state_i == ST_DMA_RECOVER1;
    assign inRec2  = state_i == ST_DMA_RECOVER2;

    // DREQ with room in the FIFO (read) or data in it (write)
    // Host request has priority
    assign dmaRdGo = ~cpuReq_i & dmaEn_i & dmaDir_i & ~dreqN_i & ~fifoFull_i;
    assign dmaWrGo = ~cpuReq_i & dmaEn_i & ~dmaDir_i & ~dreqN_i & ~fifoEmpty_i;

    always_comb begin
        term_o = '0;
        // Idle dispatch
        term_o[T_IDLE_HRD] = inIdle & cpuReq_i & rw_i;
        term_o[T_IDLE_HWR] = inIdle & cpuReq_i & ~rw_i;
        term_o[T_IDLE_DRD] = inIdle & dmaRdGo;
        term_o[T_IDLE_DWR] = inIdle & dmaWrGo;
        // Window access path
        term_o[T_STB_RD]  = inStb & rw_i;
        term_o[T_STB_WR]  = inStb & ~rw_i;
        term_o[T_HOLD_RD] = inHold & rw_i;
        term_o[T_HOLD_WR] = inHold & ~rw_i;
        // Done waits for request to drop and the ack to come back around
        term_o[T_DONE_REQ_RD]  = inDone & cpuReq_i & rw_i;
        term_o[T_DONE_REQ_WR]  = inDone & cpuReq_i & ~rw_i;
        term_o[T_DONE_ACK_RD]  = inDone & ~cpuReq_i & ~dsack_i & rw_i;
        term_o[T_DONE_ACK_WR]  = inDone & ~cpuReq_i & ~dsack_i & ~rw_i;
        term_o[T_DONE_EXIT_RD] = inDone & ~cpuReq_i & dsack_i & rw_i;
        term_o[T_DONE_EXIT_WR] = inDone & ~cpuReq_i & dsack_i & ~rw_i;
        // DMA byte path, last byte closes the longword
        term_o[T_XFER_RD]      = inXfer & dmaDir_i;
        term_o[T_XFER_WR]      = inXfer & ~dmaDir_i;
        term_o[T_XFER_RD_LAST] = inXfer & dmaDir_i & boEq3_i;
        term_o[T_XFER_WR_LAST] = inXfer & ~dmaDir_i & boEq3_i;
        term_o[T_LATCH_RD]     = inLatch & dmaDir_i;
        term_o[T_LATCH_WR]     = inLatch & ~dmaDir_i;
        term_o[T_REC1_RD]      = inRec1 & dmaDir_i;
        term_o[T_REC1_WR]      = inRec1 & ~dmaDir_i;
        term_o[T_REC2_RD]      = inRec2 & dmaDir_i;
        term_o[T_REC2_WR]      = inRec2 & ~dmaDir_i;
    end

endmodule

`default_nettype wire

//--- design/scsiSmOutputs.sv
// Output decoder for the sequencer. Terms are mutually exclusive so state codes are OR-ed
`timescale 1ns/1ps
`default_nettype none

module scsiSmOutputs import scsiDmaPkg::*; (
    input  logic [TERM_W-1:0]     term_i,
    output logic [SM_STATE_W-1:0] nextState_o,
    output logic                  re_o,
    output logic                  we_o,
    output logic                  scsiCs_o,
    output logic                  dack_o,
    output logic                  incBo_o,
    output logic                  incNi_o,
    output logic                  incNo_o,
    output logic                  s2f_o,
    output logic                  f2s_o,
    output logic                  s2cpu_o,
    output logic                  cpu2s_o,
    output logic                  setDsack_o
);

    logic toStb, toHold, toDone, toIdle;
    logic toXfer, toLatch, toRec1, toRec2;

    // Transition groups
    assign toStb   = term_i[T_IDLE_HRD] | term_i[T_IDLE_HWR];
    assign toHold  = term_i[T_STB_RD] | term_i[T_STB_WR];
    assign toDone  = term_i[T_HOLD_RD] | term_i[T_HOLD_WR]
                   | term_i[T_DONE_REQ_RD] | term_i[T_DONE_REQ_WR]
                   | term_i[T_DONE_ACK_RD] | term_i[T_DONE_ACK_WR];
    assign toIdle  = term_i[T_DONE_EXIT_RD] | term_i[T_DONE_EXIT_WR]
                   | term_i[T_REC2_RD] | term_i[T_REC2_WR];
    assign toXfer  = term_i[T_IDLE_DRD] | term_i[T_IDLE_DWR];
    assign toLatch = term_i[T_XFER_RD] | term_i[T_XFER_WR];
    assign toRec1  = term_i[T_LATCH_RD] | term_i[T_LATCH_WR];
    assign toRec2  = term_i[T_REC1_RD] | term_i[T_REC1_WR];

    // No term active means stay idle
    assign nextState_o = ({SM_STATE_W{toStb}}   & ST_CPU_STROBE)
                       | ({SM_STATE_W{toHold}}  & ST_CPU_HOLD)
                       | ({SM_STATE_W{toDone}}  & ST_CPU_DONE)
                       | ({SM_STATE_W{toIdle}}  & ST_IDLE)
                       | ({SM_STATE_W{toXfer}}  & ST_DMA_XFER)
                       | ({SM_STATE_W{toLatch}} & ST_DMA_LATCH)
                       | ({SM_STATE_W{toRec1}}  & ST_DMA_RECOVER1)
                       | ({SM_STATE_W{toRec2}}  & ST_DMA_RECOVER2);

    // Chip select and strobes span the strobe and hold states
    assign scsiCs_o = toStb | toHold;
    assign re_o     = term_i[T_IDLE_HRD] | term_i[T_STB_RD] | term_i[T_IDLE_DRD];
    assign we_o     = term_i[T_IDLE_HWR] | term_i[T_STB_WR] | term_i[T_IDLE_DWR];
    assign cpu2s_o  = term_i[T_IDLE_HWR] | term_i[T_STB_WR];
    // Read data is sampled in the hold state
    assign s2cpu_o  = term_i[T_STB_RD];
    assign setDsack_o = term_i[T_HOLD_RD] | term_i[T_HOLD_WR];

    // One DACK cycle per byte
    assign dack_o = toXfer;

    // FIFO strobes land in the latch state
    assign s2f_o   = term_i[T_XFER_RD];
    assign f2s_o   = term_i[T_XFER_WR];
    assign incBo_o = toLatch;
    assign incNi_o = term_i[T_XFER_RD_LAST];
    assign incNo_o = term_i[T_XFER_WR_LAST];

endmodule

`default_nettype wire

//--- design/scsiSm.sv
// SCSI sequencer on BCLK only. Window accesses need at least five access-phase cycles
`timescale 1ns/1ps
`default_nettype none

module scsiSm import scsiDmaPkg::*; (
    input  logic BCLK,
    input  logic CRESET_,
    input  logic cpuReq_i,
    input  logic rw_i,
    input  logic dmaEn_i,
    input  logic dmaDir_i,
    input  logic dreqN_i,
    input  logic fifoFull_i,
    input  logic fifoEmpty_i,
    input  logic boEq3_i,
    output logic scsiRe_o,
    output logic scsiWe_o,
    output logic scsiCsN_o,
    output logic dack_o,
    output logic incBo_o,
    output logic incNi_o,
    output logic incNo_o,
    output logic s2f_o,
    output logic f2s_o,
    output logic s2cpu_o,
    output logic cpu2s_o,
    output logic cpuAck_o
);

    logic [SM_STATE_W-1:0] state, nextState;
    logic [TERM_W-1:0]     term;

    // Synchronized inputs
    logic cCpuReq, cDreqN, cDsack;

    // Raw decoder outputs
    logic re, we, scsiCs, dack;
    logic incBo, incNi, incNo, s2f, f2s, s2cpu, cpu2s;
    logic setDsack;

    scsiSmInputs uInputs (
        .state_i     (state),
        .cpuReq_i    (cCpuReq),
        .rw_i        (rw_i),
        .dmaEn_i     (dmaEn_i),
        .dmaDir_i    (dmaDir_i),
        .dreqN_i     (cDreqN),
        .dsack_i     (cDsack),
        .fifoFull_i  (fifoFull_i),
        .fifoEmpty_i (fifoEmpty_i),
        .boEq3_i     (boEq3_i),
        .term_o      (term)
    );

    scsiSmOutputs uOutputs (
        .term_i      (term),
        .nextState_o (nextState),
        .re_o        (re),
        .we_o        (we),
        .scsiCs_o    (scsiCs),
        .dack_o      (dack),
        .incBo_o     (incBo),
        .incNi_o     (incNi),
        .incNo_o     (incNo),
        .s2f_o       (s2f),
        .f2s_o       (f2s),
        .s2cpu_o     (s2cpu),
        .cpu2s_o     (cpu2s),
        .setDsack_o  (setDsack)
    );

    // One flop per input, DSACK loops back from the completion latch
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cCpuReq <= 1'b0;
            cDreqN  <= 1'b1;
            cDsack  <= 1'b0;
        end else begin
            cCpuReq <= cpuReq_i;
            cDreqN  <= dreqN_i;
            cDsack  <= cpuAck_o;
        end
    end

    // State register and registered strobes
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state     <= ST_IDLE;
            scsiRe_o  <= 1'b0;
            scsiWe_o  <= 1'b0;
            scsiCsN_o <= 1'b1;
            dack_o    <= 1'b0;
            incBo_o   <= 1'b0;
            incNi_o   <= 1'b0;
            incNo_o   <= 1'b0;
            s2f_o     <= 1'b0;
            f2s_o     <= 1'b0;
            s2cpu_o   <= 1'b0;
            cpu2s_o   <= 1'b0;
        end else begin
            state     <= nextState;
            scsiRe_o  <= re;
            scsiWe_o  <= we;
            // Chip select leaves active low
            scsiCsN_o <= ~scsiCs;
            dack_o    <= dack;
            incBo_o   <= incBo;
            incNi_o   <= incNi;
            incNo_o   <= incNo;
            s2f_o     <= s2f;
            f2s_o     <= f2s;
            s2cpu_o   <= s2cpu;
            cpu2s_o   <= cpu2s;
        end
    end

    // Completion latch, set from the hold state
    // Holds until the host request is seen low
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpuAck_o <= 1'b0;
        end else if (setDsack) begin
            cpuAck_o <= 1'b1;
        end else if (!cCpuReq) begin
            cpuAck_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/dmaFifo.sv
// Longword FIFO, FIFO_DEPTH a power of two >= 2. Chip and host must not push or pop together
`timescale 1ns/1ps
`default_nettype none

module dmaFifo import scsiDmaPkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          BCLK,
    input  logic                          CRESET_,
    input  logic [7:0]                    scsiData_i,
    input  logic                          s2f_i,
    input  logic                          f2s_i,
    input  logic                          incBo_i,
    input  logic                          incNi_i,
    input  logic                          incNo_i,
    input  logic                          cpuWrite_i,
    input  logic                          cpuRead_i,
    input  fifoWord_u                     cpuWrData_i,
    output logic [7:0]                    dataToScsi_o,
    output fifoWord_u                     cpuRdData_o,
    output logic                          boEq3_o,
    output logic                          full_o,
    output logic                          empty_o,
    output logic [$clog2(FIFO_DEPTH):0]   count_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    fifoWord_u        mem [FIFO_DEPTH];
    // Extra MSB tells full from empty
    logic [PTR_W:0]   nextIn, nextOut;
    logic [1:0]       byteOff;
    logic             pushWord, popWord;

    // A longword is complete on its fourth chip byte or on a host write
    assign pushWord = cpuWrite_i | (s2f_i & incNi_i);
    assign popWord  = cpuRead_i | (f2s_i & incNo_i);

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            nextIn  <= '0;
            nextOut <= '0;
            byteOff <= 2'd0;
        end else begin
            if (pushWord) begin
                nextIn <= nextIn + 1'b1;
            end
            if (popWord) begin
                nextOut <= nextOut + 1'b1;
            end
            // Wraps from three back to zero
            if (incBo_i) begin
                byteOff <= byteOff + 2'd1;
            end
        end
    end

    // Storage, chip bytes go into the lane picked by the offset
    always_ff @(posedge BCLK) begin
        if (s2f_i) begin
            mem[nextIn[PTR_W-1:0]].bytes[byteOff] <= scsiData_i;
        end
        if (cpuWrite_i) begin
            mem[nextIn[PTR_W-1:0]] <= cpuWrData_i;
        end
    end

    // Both sides read from the next-out word
    assign cpuRdData_o  = mem[nextOut[PTR_W-1:0]];
    assign dataToScsi_o = mem[nextOut[PTR_W-1:0]].bytes[byteOff];

    assign boEq3_o = byteOff == 2'd3;
    assign count_o = nextIn - nextOut;
    assign empty_o = nextIn == nextOut;
    assign full_o  = (nextIn[PTR_W] != nextOut[PTR_W])
                   && (nextIn[PTR_W-1:0] == nextOut[PTR_W-1:0]);

endmodule

`default_nettype wire

//--- design/apbRegs.sv
// APB3 slave with no error response. Window access waits for any previous chip ack to clear
`timescale 1ns/1ps
`default_nettype none

module apbRegs import scsiDmaPkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          BCLK,
    input  logic                          CRESET_,
    input  logic                          pSel_i,
    input  logic                          pEnable_i,
    input  logic                          pWrite_i,
    input  logic [APB_ADDR_W-1:0]         pAddr_i,
    input  logic [31:0]                   pWData_i,
    output logic [31:0]                   pRData_o,
    output logic                          pReady_o,
    input  logic                          cpuAck_i,
    input  logic                          s2cpu_i,
    input  logic                          cpu2s_i,
    input  logic [7:0]                    scsiData_i,
    input  logic [7:0]                    fifoByte_i,
    input  fifoWord_u                     fifoRdData_i,
    input  logic                          fifoFull_i,
    input  logic                          fifoEmpty_i,
    input  logic [$clog2(FIFO_DEPTH):0]   fifoCount_i,
    output logic                          dmaEn_o,
    output logic                          dmaDir_o,
    output logic                          cpuReq_o,
    output logic                          rw_o,
    output logic [2:0]                    scsiAddr_o,
    output logic                          cpuWrite_o,
    output logic                          cpuRead_o,
    output fifoWord_u                     cpuWrData_o,
    output logic [7:0]                    scsiData_o
);

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic       accessPh;
    logic       isCtrl, isStatus, isFifo, isWin;
    logic       winDone;
    // Set after a window completion until the chip ack drops
    logic       waitAck;
    logic [7:0] rdHold;

    assign accessPh = pSel_i & pEnable_i;

    // Address decode, window is 0x40 to 0x5C
    assign isCtrl   = pAddr_i == REG_CTRL;
    assign isStatus = pAddr_i == REG_STATUS;
    assign isFifo   = pAddr_i == REG_FIFO;
    assign isWin    = pAddr_i[7:5] == REG_SCSI_BASE[7:5];

    // Chip register request
    assign cpuReq_o   = accessPh & isWin & ~(waitAck & cpuAck_i);
    assign rw_o       = ~pWrite_i;
    assign scsiAddr_o = pAddr_i[4:2];
    assign winDone    = cpuReq_o & cpuAck_i;

    // FIFO data port, one longword per completed access
    assign cpuWrite_o  = accessPh & isFifo & pWrite_i & ~fifoFull_i;
    assign cpuRead_o   = accessPh & isFifo & ~pWrite_i & ~fifoEmpty_i;
    assign cpuWrData_o = pWData_i;

    // Host byte goes out only while the sequencer writes a chip register
    assign scsiData_o = cpu2s_i ? pWData_i[7:0] : fifoByte_i;

    always_comb begin
        pReady_o = 1'b0;
        if (accessPh) begin
            if (isWin) begin
                pReady_o = winDone;
            end else if (isFifo) begin
                pReady_o = pWrite_i ? ~fifoFull_i : ~fifoEmpty_i;
            end else begin
                pReady_o = 1'b1;
            end
        end
    end

    always_comb begin
        pRData_o = '0;
        if (isCtrl) begin
            pRData_o[1:0] = {dmaDir_o, dmaEn_o};
        end else if (isStatus) begin
            pRData_o[8 +: CNT_W] = fifoCount_i;
            pRData_o[1:0]        = {fifoFull_i, fifoEmpty_i};
        end else if (isFifo) begin
            pRData_o = fifoRdData_i.word;
        end else if (isWin) begin
            pRData_o[7:0] = rdHold;
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            dmaEn_o  <= 1'b0;
            dmaDir_o <= 1'b0;
            waitAck  <= 1'b0;
        end else begin
            if (accessPh && pWrite_i && isCtrl) begin
                dmaEn_o  <= pWData_i[0];
                dmaDir_o <= pWData_i[1];
            end
            if (winDone) begin
                waitAck <= 1'b1;
            end else if (!cpuAck_i) begin
                waitAck <= 1'b0;
            end
        end
    end

    // Chip read data, taken in the hold state
    always_ff @(posedge BCLK) begin
        if (s2cpu_i) begin
            rdHold <= scsiData_i;
        end
    end

endmodule

`default_nettype wire

//--- design/scsiDmaTop.sv
// SCSI DMA core top. Transfers are whole longwords and the host moves all FIFO data itself
`timescale 1ns/1ps
`default_nettype none

module scsiDmaTop import scsiDmaPkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  BCLK,
    input  logic                  CRESET_,
    // APB host port
    input  logic                  pSel_i,
    input  logic                  pEnable_i,
    input  logic                  pWrite_i,
    input  logic [APB_ADDR_W-1:0] pAddr_i,
    input  logic [31:0]           pWData_i,
    output logic [31:0]           pRData_o,
    output logic                  pReady_o,
    // Chip port
    input  logic                  scsiDreqN_i,
    output logic                  scsiDack_o,
    output logic                  scsiRe_o,
    output logic                  scsiWe_o,
    output logic                  scsiCsN_o,
    output logic [2:0]            scsiAddr_o,
    input  logic [7:0]            scsiData_i,
    output logic [7:0]            scsiData_o
);

    // Register block to sequencer
    logic cpuReq, rw, dmaEn, dmaDir;
    // Sequencer strobes
    logic cpuAck, s2f, incBo, incNi, f2s, incNo, s2cpu, cpu2s;
    // FIFO side
    logic                        cpuWrite, cpuRead;
    fifoWord_u                   cpuWrData, cpuRdData;
    logic                        boEq3, full, empty;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic [7:0]                  dataToScsi;

    scsiSm uSm (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .cpuReq_i    (cpuReq),
        .rw_i        (rw),
        .dmaEn_i     (dmaEn),
        .dmaDir_i    (dmaDir),
        .dreqN_i     (scsiDreqN_i),
        .fifoFull_i  (full),
        .fifoEmpty_i (empty),
        .boEq3_i     (boEq3),
        .scsiRe_o    (scsiRe_o),
        .scsiWe_o    (scsiWe_o),
        .scsiCsN_o   (scsiCsN_o),
        .dack_o      (scsiDack_o),
        .incBo_o     (incBo),
        .incNi_o     (incNi),
        .incNo_o     (incNo),
        .s2f_o       (s2f),
        .f2s_o       (f2s),
        .s2cpu_o     (s2cpu),
        .cpu2s_o     (cpu2s),
        .cpuAck_o    (cpuAck)
    );

    dmaFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uFifo (
        .BCLK         (BCLK),
        .CRESET_      (CRESET_),
        .scsiData_i   (scsiData_i),
        .s2f_i        (s2f),
        .f2s_i        (f2s),
        .incBo_i      (incBo),
        .incNi_i      (incNi),
        .incNo_i      (incNo),
        .cpuWrite_i   (cpuWrite),
        .cpuRead_i    (cpuRead),
        .cpuWrData_i  (cpuWrData),
        .dataToScsi_o (dataToScsi),
        .cpuRdData_o  (cpuRdData),
        .boEq3_o      (boEq3),
        .full_o       (full),
        .empty_o      (empty),
        .count_o      (count)
    );

    apbRegs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uRegs (
        .BCLK         (BCLK),
        .CRESET_      (CRESET_),
        .pSel_i       (pSel_i),
        .pEnable_i    (pEnable_i),
        .pWrite_i     (pWrite_i),
        .pAddr_i      (pAddr_i),
        .pWData_i     (pWData_i),
        .pRData_o     (pRData_o),
        .pReady_o     (pReady_o),
        .cpuAck_i     (cpuAck),
        .s2cpu_i      (s2cpu),
        .cpu2s_i      (cpu2s),
        .scsiData_i   (scsiData_i),
        .fifoByte_i   (dataToScsi),
        .fifoRdData_i (cpuRdData),
        .fifoFull_i   (full),
        .fifoEmpty_i  (empty),
        .fifoCount_i  (count),
        .dmaEn_o      (dmaEn),
        .dmaDir_o     (dmaDir),
        .cpuReq_o     (cpuReq),
        .rw_o         (rw),
        .scsiAddr_o   (scsiAddr_o),
        .cpuWrite_o   (cpuWrite),
        .cpuRead_o    (cpuRead),
        .cpuWrData_o  (cpuWrData),
        .scsiData_o   (scsiData_o)
    );

endmodule

`default_nettype wire

//--- dv/tbScsiDma.sv
// Random self-checking testbench for scsiDmaTop. Assumes FIFO_DEPTH 8 and whole longword transfers
`timescale 1ns/1ps
`default_nettype none

module tbScsiDma import scsiDmaPkg::*; ();

    localparam int FIFO_DEPTH  = 8;
    localparam int CLK_PERIOD  = 40;
    // About 6000 cycles for the whole run, limit leaves wide margin
    localparam int CYCLE_LIMIT = 20000;

    logic                  BCLK;
    logic                  CRESET_;
    logic                  pSel, pEnable, pWrite;
    logic [APB_ADDR_W-1:0] pAddr;
    logic [31:0]           pWData, pRData;
    logic                  pReady;
    logic                  scsiDreqN, scsiDack, scsiRe, scsiWe, scsiCsN;
    logic [2:0]            scsiAddr;
    logic [7:0]            scsiDataIn, scsiDataOut;

    // Data stream and chip delay stream
    logic [31:0] rng, dlyRng;
    int          cycleCount;

    // Chip model: eight registers, byte source and byte sink
    logic [7:0]  chipRegs [8];
    logic [7:0]  srcQ [$];
    logic [7:0]  sinkQ [$];
    int          sinkRoom;
    logic        chipDir;
    logic        chipHold;
    logic [7:0]  curByte;
    int          gap;
    int          heldBytes;
    logic        dirStrobe;

    // Reference model
    logic [7:0]  expQ [$];
    logic [7:0]  refRegs [8];

    scsiDmaTop #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .pSel_i      (pSel),
        .pEnable_i   (pEnable),
        .pWrite_i    (pWrite),
        .pAddr_i     (pAddr),
        .pWData_i    (pWData),
        .pRData_o    (pRData),
        .pReady_o    (pReady),
        .scsiDreqN_i (scsiDreqN),
        .scsiDack_o  (scsiDack),
        .scsiRe_o    (scsiRe),
        .scsiWe_o    (scsiWe),
        .scsiCsN_o   (scsiCsN),
        .scsiAddr_o  (scsiAddr),
        .scsiData_i  (scsiDataIn),
        .scsiData_o  (scsiDataOut)
    );

    initial begin
        BCLK = 1'b0;
        forever #(CLK_PERIOD / 2) BCLK = ~BCLK;
    end

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    always @(posedge BCLK) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            stopOnError($sformatf("Timeout, run exceeded %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            stopOnError($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act));
        end
    endtask

    // Chip model, acts on the falling edge while DUT outputs are settled
    always @(negedge BCLK) begin
        if (CRESET_) begin
            // Bytes taken from the source and not yet read by the host sit in the FIFO
            heldBytes = expQ.size() - srcQ.size();
            assert (!(scsiDack && chipDir && heldBytes >= 4 * FIFO_DEPTH)) else begin
                stopOnError("DACK asserted for a read DMA byte while the FIFO was full");
            end
            if (scsiDack) begin
                // A byte moves only on a pending DREQ with the strobe of its direction
                dirStrobe = chipDir ? (scsiRe && !scsiWe) : (scsiWe && !scsiRe);
                assert (!scsiDreqN && dirStrobe) else begin
                    stopOnError("DACK without a pending DREQ or with the wrong strobe");
                end
                if (scsiWe) begin
                    sinkQ.push_back(scsiDataOut);
                    sinkRoom--;
                end else begin
                    srcQ.delete(0);
                end
                scsiDreqN = 1'b1;
                // Byte stays on the bus through the latch cycle, then 0 to 5 idle cycles
                dlyRng = xorshift32(dlyRng);
                gap    = 1 + int'(dlyRng % 6);
            end else if (scsiDreqN) begin
                if (gap > 0) begin
                    gap--;
                end else if (!chipHold && (chipDir ? srcQ.size() > 0 : sinkRoom > 0)) begin
                    if (chipDir) begin
                        curByte = srcQ[0];
                    end
                    scsiDreqN = 1'b0;
                end
            end
            // Register window
            if (!scsiCsN && scsiWe) begin
                chipRegs[scsiAddr] = scsiDataOut;
            end
            scsiDataIn = (!scsiCsN && scsiRe) ? chipRegs[scsiAddr] : curByte;
        end
    end

    // One APB transfer with setup and access phase
    task automatic apbAccess(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int waits);
        @(negedge BCLK);
        pSel   = 1'b1;
        pWrite = wr;
        pAddr  = addr;
        pWData = wdata;
        @(negedge BCLK);
        pEnable = 1'b1;
        waits   = 0;
        // Read at the rising edge, ahead of the register updates
        @(posedge BCLK);
        while (!pReady) begin
            waits++;
            @(posedge BCLK);
        end
        rdata = pRData;
        @(negedge BCLK);
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic regWrite(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] discard;
        int          waits;
        apbAccess(1'b1, addr, data, discard, waits);
    endtask

    task automatic regRead(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
        int waits;
        apbAccess(1'b0, addr, 32'h0, data, waits);
    endtask

    // Random bytes for the chip source, also queued as expected data
    task automatic loadSource(input int n);
        logic [7:0] b;
        int         i;
        for (i = 0; i < n; i++) begin
            b = 8'(nextRand());
            srcQ.push_back(b);
            expQ.push_back(b);
        end
    endtask

    // First byte lands in the most significant lane
    function automatic logic [31:0] popExpWord();
        logic [31:0] w;
        int          j;
        w = '0;
        for (j = 0; j < 4; j++) begin
            w = {w[23:0], expQ.pop_front()};
        end
        return w;
    endfunction

    task automatic drainWords(input string name, input int n);
        logic [31:0] rd;
        int          i;
        for (i = 0; i < n; i++) begin
            regRead(REG_FIFO, rd);
            checkWord(name, popExpWord(), rd);
        end
    endtask

    // Random window write, then random window read checked against the register copy
    task automatic windowPair(input string name);
        logic [2:0]            wa, ra;
        logic [31:0]           wdata, rd;
        logic [APB_ADDR_W-1:0] addr;
        wa    = 3'(nextRand());
        ra    = 3'(nextRand());
        wdata = nextRand();
        refRegs[wa] = wdata[7:0];
        addr = REG_SCSI_BASE + {wa, 2'b00};
        regWrite(addr, wdata);
        addr = REG_SCSI_BASE + {ra, 2'b00};
        regRead(addr, rd);
        checkWord(name, {24'h0, refRegs[ra]}, rd);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] w;
        int          waits;
        int          i;
        int          j;
        CRESET_    = 1'b0;
        pSel       = 1'b0;
        pEnable    = 1'b0;
        pWrite     = 1'b0;
        pAddr      = '0;
        pWData     = '0;
        scsiDreqN  = 1'b1;
        scsiDataIn = 8'h00;
        rng        = 32'd19;
        // Delay stream from the same seed
        dlyRng     = ~rng;
        cycleCount = 0;
        sinkRoom   = 0;
        chipDir    = 1'b1;
        chipHold   = 1'b0;
        curByte    = 8'h00;
        gap        = 0;
        for (i = 0; i < 8; i++) begin
            chipRegs[i] = 8'(i * 37 + 5);
            refRegs[i]  = 8'(i * 37 + 5);
        end
        repeat (16) @(negedge BCLK);
        CRESET_ = 1'b1;

        // Idle pins and empty FIFO after reset
        @(negedge BCLK);
        checkWord("resetPins", 32'b0001, {scsiDack, scsiRe, scsiWe, scsiCsN});
        regRead(REG_STATUS, rd);
        checkWord("resetStatus", 32'h1, rd);

        for (i = 0; i < 20; i++) begin
            windowPair("windowRandom");
        end

        // Read DMA, 64 bytes
        regWrite(REG_CTRL, 32'h3);
        loadSource(64);
        drainWords("readDma", 16);

        // Write DMA, 16 longwords
        regWrite(REG_CTRL, 32'h1);
        chipDir  = 1'b0;
        sinkRoom = 64;
        for (i = 0; i < 16; i++) begin
            w = nextRand();
            for (j = 0; j < 4; j++) begin
                expQ.push_back(w[31 - 8 * j -: 8]);
            end
            regWrite(REG_FIFO, w);
        end
        while (sinkQ.size() < 64) begin
            @(negedge BCLK);
        end
        repeat (20) @(negedge BCLK);
        assert (sinkQ.size() == 64) else begin
            stopOnError("Chip sink received more bytes than the host wrote");
        end
        for (i = 0; i < 64; i++) begin
            checkWord("writeDma", expQ.pop_front(), sinkQ.pop_front());
        end

        // Host idle until the FIFO fills, DMA must stall
        regWrite(REG_CTRL, 32'h3);
        chipDir = 1'b1;
        loadSource(40);
        do begin
            regRead(REG_STATUS, rd);
        end while (!rd[1]);
        repeat (40) @(negedge BCLK);
        checkWord("fullSourceLeft", 32'd8, srcQ.size());
        regRead(REG_STATUS, rd);
        checkWord("fullStatus", 32'h802, rd);
        drainWords("fullDrain", 10);

        // FIFO read while empty waits for the chip
        chipHold = 1'b1;
        loadSource(4);
        fork
            apbAccess(1'b0, REG_FIFO, 32'h0, rd, waits);
            begin
                repeat (30) @(negedge BCLK);
                chipHold = 1'b0;
            end
        join
        assert (waits >= 30) else begin
            stopOnError("FIFO read completed before any longword arrived");
        end
        checkWord("emptyStall", popExpWord(), rd);

        // Window traffic while a read DMA runs
        loadSource(32);
        for (i = 0; i < 8; i++) begin
            windowPair("windowDuringDma");
            drainWords("dmaDuringWindow", 1);
        end

        regRead(REG_STATUS, rd);
        checkWord("finalStatus", 32'h1, rd);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/scsiDmaPkg.sv
design/scsiSmInputs.sv
design/scsiSmOutputs.sv
design/scsiSm.sv
design/dmaFifo.sv
design/apbRegs.sv
design/scsiDmaTop.sv
dv/tbScsiDma.sv

//--- Bender.yml
package:
  name: scsi_dma

sources:
  - design/scsiDmaPkg.sv
  - design/scsiSmInputs.sv
  - design/scsiSmOutputs.sv
  - design/scsiSm.sv
  - design/dmaFifo.sv
  - design/apbRegs.sv
  - design/scsiDmaTop.sv
  - target: test
    files:
      - dv/tbScsiDma.sv
